// File: dv/tb_serdes_link.sv
// testbench for the serdes link test top that drives both lanes and checks tx, led and edge outputs
`default_nettype none

module tb_serdes_link;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int PATTERN_BITS   = 12;
  localparam int HEARTBEAT_BITS = 6;
  localparam int CLK_HALF_NS    = 50;    // 100 ns period
  localparam int RAND_SEED      = 79;

  // cycles spent in each test
  localparam int RESET_CYC  = 5;         // 2 in reset, 3 idle after it
  localparam int COMMA_CYC  = 1100;
  localparam int TXD_CYC    = 1000;      // carries n past 2048 so the tx heartbeat goes high
  localparam int STATUS_CYC = 300;
  localparam int EDGE_CYC   = 600;
  localparam int SWITCH_CYC = 200;
  localparam int TOTAL_CYC  = RESET_CYC + COMMA_CYC + TXD_CYC +
                              STATUS_CYC + EDGE_CYC + SWITCH_CYC;
  localparam int WATCHDOG_NS = TOTAL_CYC * 2 * CLK_HALF_NS * 12 / 10;  // plus 20 percent
  localparam int MAX_CYC     = 4096;     // history depth above the watchdog limit

  logic                         rx0_pclk = 1'b0;
  logic                         reset;
  logic                         lane_sel;
  serdes_test_pkg::rx_byte_t    rxd0;
  serdes_test_pkg::rx_byte_t    rxd1;
  logic                         rx0_los;
  logic                         rx0_lol;
  logic                         rx1_los;
  logic                         rx1_lol;
  logic                         rx0_ldr;
  logic                         rx1_ldr;
  serdes_test_pkg::tx_byte_t    txd;
  logic                         tx_comma;
  serdes_test_pkg::led_t        led;
  serdes_test_pkg::edge_count_t ldr_edges;

  // input history as the dut sampled it by lane and cycle n
  serdes_test_pkg::rx_byte_t hist_rxd [0:1][0:MAX_CYC-1];
  logic                      hist_los [0:1][0:MAX_CYC-1];
  logic                      hist_lol [0:1][0:MAX_CYC-1];
  logic                      hist_ldr [0:1][0:MAX_CYC-1];

  int   n            = 0;     // rising edges since reset fell which is the pattern count
  int   error_count  = 0;
  int   check_count  = 0;
  int   tests_run    = 0;
  int   tests_failed = 0;
  int   comma_seen   = 0;
  logic tx_hb_seen   = 1'b0;  // led bit 1 seen high at least once
  int   ldr_hold [0:1];       // cycles left before a ldr line may flip

  // expected values for the current cycle
  serdes_test_pkg::tx_byte_t    e_txd;
  logic                         e_comma;
  serdes_test_pkg::led_t        e_led;
  serdes_test_pkg::edge_count_t e_edges;

  serdes_link_test
  #(
    .pattern_bits  (PATTERN_BITS),
    .heartbeat_bits(HEARTBEAT_BITS)
  )
  dut_i
  (
    .rx0_pclk (rx0_pclk),
    .reset    (reset),
    .lane_sel (lane_sel),
    .rxd0     (rxd0),
    .rxd1     (rxd1),
    .rx0_los  (rx0_los),
    .rx0_lol  (rx0_lol),
    .rx1_los  (rx1_los),
    .rx1_lol  (rx1_lol),
    .rx0_ldr  (rx0_ldr),
    .rx1_ldr  (rx1_ldr),
    .txd      (txd),
    .tx_comma (tx_comma),
    .led      (led),
    .ldr_edges(ldr_edges)
  );

  always #CLK_HALF_NS rx0_pclk = ~rx0_pclk;

  // reference model built from the counting rules and the sampled inputs
  function automatic void predict
  (
    input  int                           cyc,
    input  logic                         sel,
    output serdes_test_pkg::tx_byte_t    x_txd,
    output logic                         x_comma,
    output serdes_test_pkg::led_t        x_led,
    output serdes_test_pkg::edge_count_t x_edges
  );
    int                        lane;
    int                        pat;
    int                        hb;
    int                        j;
    logic                      prev;
    serdes_test_pkg::rx_byte_t b;
    serdes_test_pkg::nibble_t  fold;
    lane    = sel ? 1 : 0;
    pat     = cyc % (1 << PATTERN_BITS);    // pattern counter at cycle n
    hb      = cyc % (1 << HEARTBEAT_BITS);  // rx heartbeat counter at cycle n
    x_txd   = serdes_test_pkg::tx_byte_t'(pat >> (PATTERN_BITS - 8));
    x_comma = (cyc != 0) && (cyc % (1 << serdes_test_pkg::COMMA_PERIOD_BITS) == 0);
    b       = hist_rxd[lane][cyc];           // byte register shows the sample of this edge
    fold    = b[7:4] | b[3:0];
    x_led   = {fold, hist_los[lane][cyc], hist_lol[lane][cyc],
               pat[PATTERN_BITS-1], hb[HEARTBEAT_BITS-1]};
    // a rise sampled at edge j shows in the count after edge j+1 so stop at cyc-1
    x_edges = '0;
    prev    = 1'b0;                          // tracker is clear out of reset
    for (j = 1; j < cyc; j++)
    begin
      if (hist_ldr[lane][j] && !prev)
      begin
        x_edges = x_edges + 1'b1;
      end
      prev = hist_ldr[lane][j];
    end
  endfunction

  task automatic check_byte(input string what, input serdes_test_pkg::tx_byte_t got,
                            input serdes_test_pkg::tx_byte_t exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("** Error: time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("** Error: time %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_led(input string what, input serdes_test_pkg::led_t got,
                           input serdes_test_pkg::led_t exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("** Error: time %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_edges(input string what, input serdes_test_pkg::edge_count_t got,
                             input serdes_test_pkg::edge_count_t exp);
    check_count++;
    if (got !== exp)
    begin
      error_count++;
      $display("** Error: time %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic note_failure(input string msg);
    error_count++;
    $display("failure at time %0t: %s", $time, msg);
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (error_count != errs_before)
    begin
      tests_failed++;
    end
    $display("test %0d %s finished, %0d errors", tests_run, name, error_count - errs_before);
  endtask

  task automatic drive_idle();
    rxd0    = '0;
    rxd1    = '0;
    rx0_los = 1'b0;
    rx0_lol = 1'b0;
    rx1_los = 1'b0;
    rx1_lol = 1'b0;
    rx0_ldr = 1'b0;
    rx1_ldr = 1'b0;
  endtask

  task automatic drive_random_lanes();
    rxd0    = serdes_test_pkg::rx_byte_t'($urandom);
    rxd1    = serdes_test_pkg::rx_byte_t'($urandom);
    rx0_los = 1'($urandom);
    rx0_lol = 1'($urandom);
    rx1_los = 1'($urandom);
    rx1_lol = 1'($urandom);
  endtask

  // pulse trains where each level lasts 2 to 5 cycles and a lane that is off settles low
  task automatic step_ldr(input logic lane0_on, input logic lane1_on);
    if (ldr_hold[0] == 0)
    begin
      rx0_ldr     = lane0_on && !rx0_ldr;
      ldr_hold[0] = 1 + int'($urandom_range(3, 0));
    end
    else
    begin
      ldr_hold[0] = ldr_hold[0] - 1;
    end
    if (ldr_hold[1] == 0)
    begin
      rx1_ldr     = lane1_on && !rx1_ldr;
      ldr_hold[1] = 1 + int'($urandom_range(3, 0));
    end
    else
    begin
      ldr_hold[1] = ldr_hold[1] - 1;
    end
  endtask

  // compare just after each rising edge while inputs only move on the falling edge
  always
  begin
    @(posedge rx0_pclk);
    #1;
    if (reset)
    begin
      check_byte("txd in reset", txd, '0);
      check_flag("tx_comma in reset", tx_comma, 1'b0);
      check_led("led in reset", led, '0);
      check_edges("ldr_edges in reset", ldr_edges, '0);
    end
    else
    begin
      n = n + 1;
      hist_rxd[0][n] = rxd0;
      hist_rxd[1][n] = rxd1;
      hist_los[0][n] = rx0_los;
      hist_los[1][n] = rx1_los;
      hist_lol[0][n] = rx0_lol;
      hist_lol[1][n] = rx1_lol;
      hist_ldr[0][n] = rx0_ldr;
      hist_ldr[1][n] = rx1_ldr;
      predict(n, lane_sel, e_txd, e_comma, e_led, e_edges);
      check_byte("txd", txd, e_txd);
      check_flag("tx_comma", tx_comma, e_comma);
      check_led("led", led, e_led);
      check_edges("ldr_edges", ldr_edges, e_edges);
      if (tx_comma)
      begin
        comma_seen++;
      end
      if (led[1])
      begin
        tx_hb_seen = 1'b1;  // tx heartbeat reached the led
      end
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Simulation FAILED");
    $finish;
  end

  initial
  begin
    int errs_before;
    int i;
    void'($urandom(RAND_SEED));
    reset       = 1'b1;
    lane_sel    = 1'b0;
    ldr_hold[0] = 0;
    ldr_hold[1] = 0;
    drive_idle();

    // reset values with inputs held at zero through and after reset
    errs_before = error_count;
    repeat (2) @(negedge rx0_pclk);
    reset = 1'b0;
    repeat (RESET_CYC - 2) @(negedge rx0_pclk);
    report_test("reset values", errs_before);

    // comma timing on quiet lanes
    errs_before = error_count;
    repeat (COMMA_CYC) @(negedge rx0_pclk);
    if (comma_seen != 4)
    begin
      note_failure($sformatf("saw %0d commas up to n=%0d, expected 4", comma_seen, n));
    end
    report_test("comma timing", errs_before);

    // tx byte walk and tx heartbeat
    errs_before = error_count;
    repeat (TXD_CYC) @(negedge rx0_pclk);
    if (!tx_hb_seen)
    begin
      note_failure("tx heartbeat never showed high on the led");
    end
    report_test("transmit byte", errs_before);

    // random lane status on lane 0 then lane 1
    errs_before = error_count;
    for (i = 0; i < STATUS_CYC; i++)
    begin
      @(negedge rx0_pclk);
      lane_sel = (i >= STATUS_CYC / 2);
      drive_random_lanes();
    end
    report_test("lane status", errs_before);

    // edge counting on both ldr lines
    errs_before = error_count;
    for (i = 0; i < EDGE_CYC; i++)
    begin
      @(negedge rx0_pclk);
      lane_sel = (i < EDGE_CYC / 2);
      step_ldr(1'b1, 1'b1);
    end
    report_test("edge counting", errs_before);

    // lane switching where lanes carry different flags and only lane 1 keeps pulsing
    errs_before = error_count;
    for (i = 0; i < SWITCH_CYC; i++)
    begin
      @(negedge rx0_pclk);
      lane_sel = !lane_sel;
      rxd0     = serdes_test_pkg::rx_byte_t'($urandom);
      rxd1     = serdes_test_pkg::rx_byte_t'($urandom);
      rx0_los  = 1'b1;
      rx0_lol  = 1'b0;
      rx1_los  = 1'b0;
      rx1_lol  = 1'b1;
      step_ldr(1'b0, 1'b1);
    end
    @(posedge rx0_pclk);
    #2;  // let the last compare run
    report_test("lane switching", errs_before);

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0 && check_count > 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
logic/serdes_test_pkg.sv
logic/link_pattern_gen.sv
logic/lane_rx_monitor.sv
logic/serdes_link_test.sv
dv/tb_serdes_link.sv

// File: logic/lane_rx_monitor.sv
// receive lane monitor: registers byte and loss flags, heartbeat and ldr edge count per lane
`default_nettype none

module lane_rx_monitor
#(
  parameter int heartbeat_bits = serdes_test_pkg::DEF_HEARTBEAT_BITS
)
(
  input  logic                         rx0_pclk,
  input  logic                         reset,
  input  serdes_test_pkg::rx_byte_t    rxd,           // lane byte from the pcs
  input  logic                         los,           // loss of signal
  input  logic                         lol,           // cdr loss of lock
  input  logic                         ldr,           // low speed data recovery line
  input  logic                         tx_heartbeat,  // from the pattern generator
  output serdes_test_pkg::led_t        status,        // full led word for this lane
  output serdes_test_pkg::edge_count_t ldr_edges      // rising edges seen on ldr
);

  serdes_test_pkg::rx_byte_t    rxd_q;     // sampled lane byte
  logic                         los_q;     // sampled loss of signal
  logic                         lol_q;     // sampled loss of lock
  logic [heartbeat_bits-1:0]    hb_ctr;    // rx heartbeat counter
  logic [1:0]                   ldr_trk;   // [1] newest sample, [0] previous one
  serdes_test_pkg::edge_count_t edge_cnt;  // running rising edge count
  serdes_test_pkg::nibble_t     byte_fold; // both nibbles of the byte or'ed
  logic                         rx_hb;     // heartbeat msb

  // input register stage, one cycle of latency for byte and flags
  always_ff @(posedge rx0_pclk)
  begin
    if (reset)
    begin
      rxd_q <= '0;
      los_q <= 1'b0;
      lol_q <= 1'b0;
    end
    else
    begin
      rxd_q <= rxd;
      los_q <= los;
      lol_q <= lol;
    end
  end

  // heartbeat, same counting rule as the tx pattern counter
  always_ff @(posedge rx0_pclk)
  begin
    if (reset)
    begin
      hb_ctr <= '0;
    end
    else
    begin
      hb_ctr <= hb_ctr + 1'b1;
    end
  end

  assign rx_hb = hb_ctr[heartbeat_bits-1];

  // ldr edge tracker
  // the new sample shifts in at the top, the old one drops to bit 0
  always_ff @(posedge rx0_pclk)
  begin
    if (reset)
    begin
      ldr_trk <= 2'b00;
    end
    else
    begin
      ldr_trk <= {ldr, ldr_trk[1]};
    end
  end

  // count on "new high, old low", one cycle after the tracker shows it
  always_ff @(posedge rx0_pclk)
  begin
    if (reset)
    begin
      edge_cnt <= '0;
    end
    else if (ldr_trk == 2'b10)
    begin
      edge_cnt <= edge_cnt + 1'b1;  // wraps at 2**20
    end
  end

  assign ldr_edges = edge_cnt;

  // led word for this lane
  // upper nibble shows activity on any byte bit, lower nibble is the flags
  assign byte_fold = rxd_q[7:4] | rxd_q[3:0];
  assign status    = {byte_fold, los_q, lol_q, tx_heartbeat, rx_hb};

  // edge count moves by at most one per cycle, outside of a reset
  a_edge_step: assert property (
    @(posedge rx0_pclk) disable iff (reset)
      !$past(reset) |->
        (edge_cnt == $past(edge_cnt)) ||
        (edge_cnt == serdes_test_pkg::edge_count_t'($past(edge_cnt) + 1'b1))
  ) else $error("ldr edge count jumped by more than one");

endmodule

`default_nettype wire

// File: logic/link_pattern_gen.sv
// link pattern generator: free running counter, tx byte, periodic comma and tx heartbeat
`default_nettype none

module link_pattern_gen
#(
  parameter int pattern_bits = serdes_test_pkg::DEF_PATTERN_BITS  // 9 or more
)
(
  input  logic                      rx0_pclk,
  input  logic                      reset,
  output serdes_test_pkg::tx_byte_t txd,          // top byte of the counter
  output logic                      tx_comma,     // one cycle pulse every 256 cycles
  output logic                      tx_heartbeat  // counter msb, slow blink
);

  localparam int tx_bits    = $bits(serdes_test_pkg::tx_byte_t);
  localparam int comma_bits = serdes_test_pkg::COMMA_PERIOD_BITS;

  logic [pattern_bits-1:0] pattern_ctr;  // free running, one step per pclk
  logic                    comma_q;      // registered comma flag

  // counter: holds n at cycle n after reset falls
  always_ff @(posedge rx0_pclk)
  begin
    if (reset)
    begin
      pattern_ctr <= '0;
    end
    else
    begin
      pattern_ctr <= pattern_ctr + 1'b1;  // wraps at 2**pattern_bits
    end
  end

  // comma is raised the cycle after the low byte reads all ones,
  // i.e. on every nonzero multiple of 256
  always_ff @(posedge rx0_pclk)
  begin
    if (reset)
    begin
      comma_q <= 1'b0;
    end
    else
    begin
      comma_q <= &pattern_ctr[comma_bits-1:0];
    end
  end

  assign txd          = pattern_ctr[pattern_bits-1 -: tx_bits];  // slow walking byte
  assign tx_comma     = comma_q;
  assign tx_heartbeat = pattern_ctr[pattern_bits-1];            // same bit as txd msb

  // comma is a single cycle pulse, never back to back
  a_comma_single: assert property (
    @(posedge rx0_pclk) disable iff (reset)
      tx_comma |=> !tx_comma
  ) else $error("tx_comma high on two consecutive cycles");

  // the tx byte only moves when the bits below it roll over to zero
  a_txd_on_wrap: assert property (
    @(posedge rx0_pclk) disable iff (reset)
      $changed(txd) |-> (pattern_ctr[pattern_bits-tx_bits-1:0] == '0)
  ) else $error("txd changed without a wrap of the lower pattern bits");

endmodule

`default_nettype wire

// File: logic/serdes_link_test.sv
// serdes link test top: pattern generator, two lane monitors and lane select led display
`default_nettype none

module serdes_link_test
#(
  parameter int pattern_bits   = serdes_test_pkg::DEF_PATTERN_BITS,   // 9 or more
  parameter int heartbeat_bits = serdes_test_pkg::DEF_HEARTBEAT_BITS
)
(
  input  logic                         rx0_pclk,   // recovered rx clock, whole design
  input  logic                         reset,      // sync, active high
  input  logic                         lane_sel,   // 1: show lane 1, 0: show lane 0
  input  serdes_test_pkg::rx_byte_t    rxd0,
  input  serdes_test_pkg::rx_byte_t    rxd1,
  input  logic                         rx0_los,
  input  logic                         rx0_lol,
  input  logic                         rx1_los,
  input  logic                         rx1_lol,
  input  logic                         rx0_ldr,
  input  logic                         rx1_ldr,
  output serdes_test_pkg::tx_byte_t    txd,        // to both tx channels
  output logic                         tx_comma,   // k flag for the tx byte
  output serdes_test_pkg::led_t        led,
  output serdes_test_pkg::edge_count_t ldr_edges
);

  logic                         tx_heartbeat;  // pattern counter msb to both lanes
  serdes_test_pkg::led_t        lane0_status;
  serdes_test_pkg::led_t        lane1_status;
  serdes_test_pkg::edge_count_t lane0_edges;
  serdes_test_pkg::edge_count_t lane1_edges;

  // tx side: one pattern feeds both channels
  link_pattern_gen
  #(
    .pattern_bits(pattern_bits)
  )
  pattern_gen_i
  (
    .rx0_pclk    (rx0_pclk),
    .reset       (reset),
    .txd         (txd),
    .tx_comma    (tx_comma),
    .tx_heartbeat(tx_heartbeat)
  );

  // lane 0 monitor
  lane_rx_monitor
  #(
    .heartbeat_bits(heartbeat_bits)
  )
  lane0_mon_i
  (
    .rx0_pclk    (rx0_pclk),
    .reset       (reset),
    .rxd         (rxd0),
    .los         (rx0_los),
    .lol         (rx0_lol),
    .ldr         (rx0_ldr),
    .tx_heartbeat(tx_heartbeat),
    .status      (lane0_status),
    .ldr_edges   (lane0_edges)
  );

  // lane 1 monitor, same clock here since there is only one pclk
  lane_rx_monitor
  #(
    .heartbeat_bits(heartbeat_bits)
  )
  lane1_mon_i
  (
    .rx0_pclk    (rx0_pclk),
    .reset       (reset),
    .rxd         (rxd1),
    .los         (rx1_los),
    .lol         (rx1_lol),
    .ldr         (rx1_ldr),
    .tx_heartbeat(tx_heartbeat),
    .status      (lane1_status),
    .ldr_edges   (lane1_edges)
  );

  // display select
  // purely combinational, so led and edge count switch in the same cycle
  always_comb
  begin
    if (lane_sel)
    begin
      led       = lane1_status;
      ldr_edges = lane1_edges;
    end
    else
    begin
      led       = lane0_status;
      ldr_edges = lane0_edges;
    end
  end

endmodule

`default_nettype wire

// File: logic/serdes_test_pkg.sv
// serdes link test package: shared byte, led and counter types plus default sizes
`default_nettype none

package serdes_test_pkg;

  // data path widths
  typedef logic [7:0]  rx_byte_t;     // one received byte from the pcs, 8b mode
  typedef logic [7:0]  tx_byte_t;     // one transmitted byte to the pcs
  typedef logic [3:0]  nibble_t;      // half byte, used when folding a byte onto leds

  // user visible status
  typedef logic [7:0]  led_t;         // board led bank
  typedef logic [19:0] edge_count_t;  // low speed ldr rising edge count

  // comma timing
  // the comma fires after the low byte of the pattern counter was all ones,
  // so it repeats every 2**COMMA_PERIOD_BITS cycles
  localparam int COMMA_PERIOD_BITS = 8;

  // default counter sizes for the real clock rate
  // pattern counter: top byte walks slowly enough to be read on a scope
  localparam int DEF_PATTERN_BITS = 31;
  // heartbeat: top bit blinks at a visible rate on the led
  localparam int DEF_HEARTBEAT_BITS = 28;

  // notes on use
  // pattern_bits must leave room for the tx byte plus at least one bit
  // below it, so it has to be 9 or more
  // heartbeat_bits only needs to be 1 or more, its top bit goes to the led
  // the edge counter wraps silently at 2**20 edges

endpackage

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# compile the serdes link test with verilator and run the testbench
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  --timescale 1ns/1ps -Wno-fatal \
  --top-module tb_serdes_link \
  -f list.f \
  -o tb_serdes_link

./obj_dir/tb_serdes_link | tee "$LOG"

if grep -q "Simulation FAILED" "$LOG"; then
  echo "run failed, see $LOG"
  exit 1
fi

if ! grep -q "Simulation PASSED" "$LOG"; then
  echo "run ended without a result, see $LOG"
  exit 1
fi

echo "run passed"
